// File: rom_image.hex
c0de00ff
c0de04fb
c0de08f7
c0de0cf3
c0de10ef
c0de14eb
c0de18e7
c0de1ce3
c0de20df
c0de24db
c0de28d7
c0de2cd3
c0de30cf
c0de34cb
c0de38c7
c0de3cc3
c0de40bf
c0de44bb
c0de48b7
c0de4cb3
c0de50af
c0de54ab
c0de58a7
c0de5ca3
c0de609f
c0de649b
c0de6897
c0de6c93
c0de708f
c0de748b
c0de7887
c0de7c83

// File: tl_golden.txt
# test chan opcode param size source address(hex) beats, then per beat d_opcode d_param denied data
# chan A host A, C Release, P Get with Release, S stalled Acquire, E GrantAck to sink in address
# chan D collects beats only, data x is not compared
1 A 4 0 2 1 0014 1 1 0 0 c0de14eb
1 A 4 0 3 2 0020 2 1 0 0 c0de20df 1 0 0 c0de24db
1 A 4 0 4 0 0030 4 1 0 0 c0de30cf 1 0 0 c0de34cb 1 0 0 c0de38c7 1 0 0 c0de3cc3
1 A 4 0 4 3 0070 4 1 0 0 c0de708f 1 0 0 c0de748b 1 0 0 c0de7887 1 0 0 c0de7c83
1 A 4 0 4 1 0000 4 1 0 0 c0de00ff 1 0 0 c0de04fb 1 0 0 c0de08f7 1 0 0 c0de0cf3
1 A 4 0 3 0 0068 2 1 0 0 c0de6897 1 0 0 c0de6c93
1 A 4 0 2 2 007c 1 1 0 0 c0de7c83
3 A 0 0 2 1 0008 1 0 0 1 x
3 A 1 0 2 3 000c 1 0 0 1 x
3 A 6 1 4 2 0040 1 4 2 1 x
3 E 0 0 0 0 0000 0
3 A 7 1 3 0 0018 1 4 2 1 x
3 E 0 0 0 0 0000 0
4 C 6 1 4 3 0040 1 6 0 0 x
4 C 6 2 3 0 0010 1 6 0 0 x
2 A 6 0 4 0 0040 4 5 3 0 c0de40bf 5 3 0 c0de44bb 5 3 0 c0de48b7 5 3 0 c0de4cb3
2 A 7 0 3 1 0018 2 5 3 0 c0de18e7 5 3 0 c0de1ce3
2 A 6 0 4 2 0050 4 5 3 0 c0de50af 5 3 0 c0de54ab 5 3 0 c0de58a7 5 3 0 c0de5ca3
2 A 7 0 2 3 0004 1 5 3 0 c0de04fb
5 S 6 0 3 1 0060 0
5 E 0 0 0 0 0002 0
5 D 6 0 3 1 0060 2 5 3 0 c0de609f 5 3 0 c0de649b
6 P 4 0 3 2 0028 3 6 0 0 x 1 0 0 c0de28d7 1 0 0 c0de2cd3
6 P 4 0 4 1 0010 5 6 0 0 x 1 0 0 c0de10ef 1 0 0 c0de14eb 1 0 0 c0de18e7 1 0 0 c0de1ce3

// File: filelist.f
tl_pkg.sv
tl_burst_tracker.sv
tl_sink_allocator.sv
tl_d_arbiter.sv
tl_rom_terminator.sv
tl_rom_device.sv
tl_rom_subsystem.sv
tb_tl_rom_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_tl_rom_subsystem
FILELIST  := filelist.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_tl_rom_subsystem.sv
`timescale 1ns/10ps

module tb_tl_rom_subsystem;

  localparam int WaitLimit   = 200;
  localparam int StallCycles = 20;

  // One expected D beat as listed in the golden file
  typedef struct packed {
    logic [2:0]  opcode;
    logic [2:0]  param;
    logic        denied;
    logic        check;
    logic [31:0] data;
  } beat_exp_t;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        host_a_valid;
  tl_pkg::tl_a_host_t          host_a;
  logic                        host_a_ready;
  logic                        host_c_valid;
  tl_pkg::tl_c_t               host_c;
  logic                        host_c_ready;
  logic                        host_d_valid;
  tl_pkg::tl_d_host_t          host_d;
  logic                        host_d_ready;
  logic                        host_e_valid;
  tl_pkg::tl_e_t               host_e;
  logic                        host_e_ready;

  tl_pkg::tl_d_host_t          beat_q[$];
  beat_exp_t                   exp_q[$];
  logic [31:0]                 lfsr;
  logic [tl_pkg::SinkNums-1:0] sink_free;
  int                          errors;
  int                          test_start_errors;
  int                          tests_run;
  int                          tests_failed;

  tl_rom_subsystem dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid),
    .host_a_i       (host_a),
    .host_a_ready_o (host_a_ready),
    .host_c_valid_i (host_c_valid),
    .host_c_i       (host_c),
    .host_c_ready_o (host_c_ready),
    .host_d_valid_o (host_d_valid),
    .host_d_o       (host_d),
    .host_d_ready_i (host_d_ready),
    .host_e_valid_i (host_e_valid),
    .host_e_i       (host_e),
    .host_e_ready_o (host_e_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Random host D back-pressure takes one LFSR bit per cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      lfsr = lfsr_step(lfsr);
      host_d_ready = lfsr[0];
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && host_d_valid && host_d_ready) begin
      beat_q.push_back(host_d);
    end
  end

  function automatic int lowest_free_sink();
    for (int i = 0; i < tl_pkg::SinkNums; i++) begin
      if (sink_free[i]) return i;
    end
    return -1;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic flag_error(input string what);
    $display("ERROR %0t ns %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input int id);
    if (id >= 0) begin
      tests_run++;
      if (errors != test_start_errors) tests_failed++;
      $display("test %0d finished with %0d errors", id, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  task automatic drive_request(input string chan, input int op, input int param, input int size,
                               input int src, input logic [15:0] addr);
    int   cycles;
    logic a_pend;
    logic c_pend;
    logic e_pend;
    a_pend = (chan == "A") || (chan == "S") || (chan == "P");
    c_pend = (chan == "C") || (chan == "P");
    e_pend = (chan == "E");
    @(negedge clk_i);
    host_a         = '0;
    host_a.opcode  = tl_pkg::tl_a_op_e'(op[2:0]);
    host_a.param   = param[2:0];
    host_a.size    = size[tl_pkg::SizeWidth-1:0];
    host_a.source  = src[tl_pkg::HostSourceWidth-1:0];
    host_a.address = addr;
    host_a.mask    = '1;
    // Release rides along with the Get in a paired record
    host_c         = '0;
    host_c.opcode  = 3'd6;
    host_c.param   = (chan == "C") ? param[2:0] : 3'd0;
    host_c.size    = size[tl_pkg::SizeWidth-1:0];
    host_c.source  = src[tl_pkg::HostSourceWidth-1:0];
    host_c.address = addr;
    host_e.sink    = addr[tl_pkg::SinkWidth-1:0];
    host_a_valid   = a_pend;
    host_c_valid   = c_pend;
    host_e_valid   = e_pend;
    cycles = 0;
    while ((a_pend || c_pend || e_pend) && cycles < WaitLimit) begin
      @(posedge clk_i);
      if (host_a_valid && host_a_ready) a_pend = 1'b0;
      if (host_c_valid && host_c_ready) c_pend = 1'b0;
      if (host_e_valid && host_e_ready) begin
        e_pend = 1'b0;
        sink_free[host_e.sink] = 1'b1;
      end
      @(negedge clk_i);
      host_a_valid = a_pend;
      host_c_valid = c_pend;
      host_e_valid = e_pend;
      cycles++;
    end
    if (a_pend || c_pend || e_pend) begin
      flag_error($sformatf("%s request was not accepted within %0d cycles", chan, WaitLimit));
      host_a_valid = 1'b0;
      host_c_valid = 1'b0;
      host_e_valid = 1'b0;
    end
  endtask

  // Sinks are exhausted, so host D must stay quiet
  task automatic expect_stall();
    logic seen;
    seen = 1'b0;
    for (int cycles = 0; cycles < StallCycles; cycles++) begin
      @(posedge clk_i);
      if (host_d_valid) seen = 1'b1;
    end
    if (seen) flag_error("host D went valid while every sink id was in use");
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  task automatic wait_beats(input int nb);
    int cycles;
    cycles = 0;
    while (beat_q.size() < nb && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic check_beats(input int nb, input int size, input int src);
    tl_pkg::tl_d_host_t b;
    beat_exp_t          e;
    int                 sink_exp;
    logic               new_msg;
    sink_exp = 0;
    if (beat_q.size() < nb) begin
      flag_error($sformatf("timed out with %0d of %0d D beats", beat_q.size(), nb));
      beat_q.delete();
    end else begin
      // A paired Get and Release may answer in either order but never interleave
      if (nb > 1 && beat_q[0].opcode != exp_q[0].opcode) exp_q.push_back(exp_q.pop_front());
      for (int i = 0; i < nb; i++) begin
        b = beat_q.pop_front();
        e = exp_q[i];
        new_msg = 1'b1;
        if (i > 0) new_msg = (e.opcode != exp_q[i-1].opcode);
        if (new_msg && e.opcode inside {tl_pkg::Grant, tl_pkg::GrantData}) begin
          sink_exp = lowest_free_sink();
          if (sink_exp < 0) flag_error("Grant arrived although no sink id was free");
          else sink_free[sink_exp] = 1'b0;
        end
        if (b.opcode !== e.opcode) begin
          mismatch($sformatf("host_d.opcode[%0d]", i), b.opcode, e.opcode);
        end
        if (b.param !== e.param) mismatch($sformatf("host_d.param[%0d]", i), b.param, e.param);
        if (b.denied !== e.denied) begin
          mismatch($sformatf("host_d.denied[%0d]", i), b.denied, e.denied);
        end
        if (b.corrupt !== 1'b0) begin
          mismatch($sformatf("host_d.corrupt[%0d]", i), b.corrupt, 1'b0);
        end
        if (b.source !== src[tl_pkg::HostSourceWidth-1:0]) begin
          mismatch($sformatf("host_d.source[%0d]", i), b.source, src);
        end
        if (b.size !== size[tl_pkg::SizeWidth-1:0]) begin
          mismatch($sformatf("host_d.size[%0d]", i), b.size, size);
        end
        if (e.opcode inside {tl_pkg::Grant, tl_pkg::GrantData} &&
            b.sink !== sink_exp[tl_pkg::SinkWidth-1:0]) begin
          mismatch($sformatf("host_d.sink[%0d]", i), b.sink, sink_exp);
        end
        if (e.check && b.data !== e.data) begin
          mismatch($sformatf("host_d.data[%0d]", i), b.data, e.data);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Golden replay
  ////////////////////////////////////////

  initial begin
    string       tok;
    string       chan;
    string       line;
    string       dtok;
    int          fd;
    int          code;
    int          test_id;
    int          cur_test;
    int          op;
    int          param;
    int          size;
    int          src;
    int          nb;
    int          dop;
    int          dparam;
    int          dden;
    logic [15:0] addr;
    beat_exp_t   e;
    logic        bad;
    host_a_valid      = 1'b0;
    host_a            = '0;
    host_c_valid      = 1'b0;
    host_c            = '0;
    host_d_ready      = 1'b1;
    host_e_valid      = 1'b0;
    host_e            = '0;
    rst_ni            = 1'b0;
    lfsr              = 32'h716895a5;
    sink_free         = '1;
    errors            = 0;
    test_start_errors = 0;
    tests_run         = 0;
    tests_failed      = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen("tl_golden.txt", "r");
    if (fd == 0) begin
      flag_error("cannot open tl_golden.txt");
    end else begin
      cur_test = -1;
      bad = 1'b0;
      while (!bad && $fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
        end else begin
          test_id = tok.atoi();
          if (test_id != cur_test) begin
            close_test(cur_test);
            cur_test = test_id;
          end
          code = $fscanf(fd, " %s %d %d %d %d %h %d", chan, op, param, size, src, addr, nb);
          if (code != 7) bad = 1'b1;
          exp_q.delete();
          for (int i = 0; i < nb && !bad; i++) begin
            if ($fscanf(fd, " %d %d %d %s", dop, dparam, dden, dtok) != 4) begin
              bad = 1'b1;
            end else begin
              e.opcode = dop[2:0];
              e.param  = dparam[2:0];
              e.denied = dden[0];
              e.check  = (dtok != "x");
              e.data   = e.check ? dtok.atohex() : '0;
              exp_q.push_back(e);
            end
          end
          if (bad) begin
            flag_error($sformatf("malformed golden record in test %0d", test_id));
          end else begin
            if (chan != "D") drive_request(chan, op, param, size, src, addr);
            if (chan == "S") begin
              expect_stall();
            end else if (nb > 0) begin
              wait_beats(nb);
              check_beats(nb, size, src);
            end
          end
        end
      end
      close_test(cur_test);
      $fclose(fd);
    end

    repeat (10) @(negedge clk_i);
    if (beat_q.size() != 0) flag_error("host D delivered beats that no request asked for");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tl_rom_subsystem.sv
`timescale 1ns/10ps

module tl_rom_subsystem (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               host_a_valid_i,
  input  tl_pkg::tl_a_host_t host_a_i,
  output logic               host_a_ready_o,
  input  logic               host_c_valid_i,
  input  tl_pkg::tl_c_t      host_c_i,
  output logic               host_c_ready_o,
  output logic               host_d_valid_o,
  output tl_pkg::tl_d_host_t host_d_o,
  input  logic               host_d_ready_i,
  input  logic               host_e_valid_i,
  input  tl_pkg::tl_e_t      host_e_i,
  output logic               host_e_ready_o
);

  logic                                     dev_a_valid;
  tl_pkg::tl_a_dev_t                        dev_a;
  logic                                     dev_a_ready;
  logic                                     dev_d_valid;
  tl_pkg::tl_d_dev_t                        dev_d;
  logic                                     dev_d_ready;
  logic [tl_pkg::DSrcNum-1:0]               arb_valid;
  tl_pkg::tl_d_host_t [tl_pkg::DSrcNum-1:0] arb_req;
  logic [tl_pkg::DSrcNum-1:0]               arb_ready;
  logic                                     merged_valid;
  tl_pkg::tl_d_host_t                       merged;
  logic                                     merged_ready;
  logic                                     d_first;
  logic                                     d_last;

  // GrantAck needs no back-pressure
  assign host_e_ready_o = 1'b1;

  tl_rom_terminator u_terminator (
    .host_a_valid_i (host_a_valid_i),
    .host_a_i       (host_a_i),
    .host_a_ready_o (host_a_ready_o),
    .host_c_valid_i (host_c_valid_i),
    .host_c_i       (host_c_i),
    .host_c_ready_o (host_c_ready_o),
    .dev_a_valid_o  (dev_a_valid),
    .dev_a_o        (dev_a),
    .dev_a_ready_i  (dev_a_ready),
    .dev_d_valid_i  (dev_d_valid),
    .dev_d_i        (dev_d),
    .dev_d_ready_o  (dev_d_ready),
    .arb_valid_o    (arb_valid),
    .arb_o          (arb_req),
    .arb_ready_i    (arb_ready)
  );

  tl_d_arbiter u_d_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (arb_valid),
    .req_i       (arb_req),
    .req_ready_o (arb_ready),
    .out_valid_o (merged_valid),
    .out_o       (merged),
    .out_ready_i (merged_ready),
    .last_i      (d_last)
  );

  tl_sink_allocator u_sink_allocator (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (merged_valid),
    .in_i           (merged),
    .in_ready_o     (merged_ready),
    .first_i        (d_first),
    .host_d_valid_o (host_d_valid_o),
    .host_d_o       (host_d_o),
    .host_d_ready_i (host_d_ready_i),
    .host_e_valid_i (host_e_valid_i),
    .host_e_i       (host_e_i)
  );

  // Watches the host D channel as the host sees it
  tl_burst_tracker u_burst_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .d_valid_i (host_d_valid_o),
    .d_ready_i (host_d_ready_i),
    .d_i       (host_d_o),
    .first_o   (d_first),
    .last_o    (d_last)
  );

  tl_rom_device u_rom_device (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (dev_a_valid),
    .a_i       (dev_a),
    .a_ready_o (dev_a_ready),
    .d_valid_o (dev_d_valid),
    .d_o       (dev_d),
    .d_ready_i (dev_d_ready)
  );

endmodule

// File: tl_rom_device.sv
`timescale 1ns/10ps

module tl_rom_device (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              a_valid_i,
  input  tl_pkg::tl_a_dev_t a_i,
  output logic              a_ready_o,
  output logic              d_valid_o,
  output tl_pkg::tl_d_dev_t d_o,
  input  logic              d_ready_i
);

  logic [tl_pkg::DataWidth-1:0]         rom [tl_pkg::RomWords];
  logic                                 busy_q;
  logic [tl_pkg::BeatCntWidth-1:0]      left_q;
  logic                                 get_q;
  logic [tl_pkg::SizeWidth-1:0]         size_q;
  logic [tl_pkg::DeviceSourceWidth-1:0] source_q;
  logic [$clog2(tl_pkg::RomWords)-1:0]  idx_q;
  logic [tl_pkg::AddrWidth-1:0]         base;
  logic                                 a_fire;
  logic                                 d_fire;

  initial begin
    $readmemh("rom_image.hex", rom);
  end

  assign a_ready_o = !busy_q;
  assign d_valid_o = busy_q;
  assign a_fire    = a_valid_i && a_ready_o;
  assign d_fire    = busy_q && d_ready_i;

  // Burst starts at the size-aligned address
  assign base = (a_i.address >> a_i.size) << a_i.size;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      left_q <= '0;
    end else if (a_fire) begin
      busy_q <= 1'b1;
      left_q <= (a_i.opcode == tl_pkg::Get) ? tl_pkg::burst_beats(a_i.size) : 1;
    end else if (d_fire) begin
      busy_q <= (left_q != 1);
      left_q <= left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      get_q    <= (a_i.opcode == tl_pkg::Get);
      size_q   <= a_i.size;
      source_q <= a_i.source;
      idx_q    <= base[$clog2(tl_pkg::RomWords)+1:2];
    end else if (d_fire) begin
      idx_q    <= idx_q + 1'b1;
    end
  end

  // Anything but Get is refused
  always_comb begin
    d_o        = '0;
    d_o.opcode = get_q ? tl_pkg::AccessAckData : tl_pkg::AccessAck;
    d_o.size   = size_q;
    d_o.source = source_q;
    d_o.denied = !get_q;
    d_o.data   = get_q ? rom[idx_q] : '0;
  end

endmodule

// File: tl_rom_terminator.sv
`timescale 1ns/10ps

module tl_rom_terminator (
  input  logic                                     host_a_valid_i,
  input  tl_pkg::tl_a_host_t                       host_a_i,
  output logic                                     host_a_ready_o,
  input  logic                                     host_c_valid_i,
  input  tl_pkg::tl_c_t                            host_c_i,
  output logic                                     host_c_ready_o,
  output logic                                     dev_a_valid_o,
  output tl_pkg::tl_a_dev_t                        dev_a_o,
  input  logic                                     dev_a_ready_i,
  input  logic                                     dev_d_valid_i,
  input  tl_pkg::tl_d_dev_t                        dev_d_i,
  output logic                                     dev_d_ready_o,
  output logic [tl_pkg::DSrcNum-1:0]               arb_valid_o,
  output tl_pkg::tl_d_host_t [tl_pkg::DSrcNum-1:0] arb_o,
  input  logic [tl_pkg::DSrcNum-1:0]               arb_ready_i
);

  logic is_acq;
  logic allowed;

  assign is_acq = host_a_i.opcode inside {tl_pkg::AcquireBlock, tl_pkg::AcquirePerm};

  // Reads pass, and so do Acquires that ask for a shared copy
  always_comb begin
    if (host_a_i.opcode == tl_pkg::Get) begin
      allowed = 1'b1;
    end else if (is_acq) begin
      allowed = (host_a_i.param == tl_pkg::NtoB);
    end else begin
      allowed = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Host A
  ////////////////////////////////////////

  assign dev_a_valid_o               = host_a_valid_i && allowed;
  assign arb_valid_o[tl_pkg::DSrcDeny] = host_a_valid_i && !allowed;
  assign host_a_ready_o = allowed ? dev_a_ready_i : arb_ready_i[tl_pkg::DSrcDeny];

  // Acquires become Gets tagged in the top source bit
  always_comb begin
    dev_a_o         = '0;
    dev_a_o.opcode  = is_acq ? tl_pkg::Get : host_a_i.opcode;
    dev_a_o.size    = host_a_i.size;
    dev_a_o.source  = {is_acq, host_a_i.source};
    dev_a_o.address = host_a_i.address;
    dev_a_o.mask    = host_a_i.mask;
    dev_a_o.corrupt = host_a_i.corrupt;
    dev_a_o.data    = host_a_i.data;
  end

  always_comb begin
    arb_o[tl_pkg::DSrcDeny]        = '0;
    arb_o[tl_pkg::DSrcDeny].opcode = is_acq ? tl_pkg::Grant : tl_pkg::AccessAck;
    arb_o[tl_pkg::DSrcDeny].param  = is_acq ? tl_pkg::toN : 3'd0;
    arb_o[tl_pkg::DSrcDeny].size   = host_a_i.size;
    arb_o[tl_pkg::DSrcDeny].source = host_a_i.source;
    arb_o[tl_pkg::DSrcDeny].denied = 1'b1;
  end

  ////////////////////////////////////////
  // Host C
  ////////////////////////////////////////

  // Nothing to write back, so every Release is simply acknowledged
  assign arb_valid_o[tl_pkg::DSrcRel] = host_c_valid_i;
  assign host_c_ready_o               = arb_ready_i[tl_pkg::DSrcRel];

  always_comb begin
    arb_o[tl_pkg::DSrcRel]        = '0;
    arb_o[tl_pkg::DSrcRel].opcode = tl_pkg::ReleaseAck;
    arb_o[tl_pkg::DSrcRel].size   = host_c_i.size;
    arb_o[tl_pkg::DSrcRel].source = host_c_i.source;
  end

  ////////////////////////////////////////
  // Device D
  ////////////////////////////////////////

  assign arb_valid_o[tl_pkg::DSrcGnt] = dev_d_valid_i;
  assign dev_d_ready_o                = arb_ready_i[tl_pkg::DSrcGnt];

  always_comb begin
    arb_o[tl_pkg::DSrcGnt]         = '0;
    arb_o[tl_pkg::DSrcGnt].opcode  = dev_d_i.opcode;
    arb_o[tl_pkg::DSrcGnt].size    = dev_d_i.size;
    arb_o[tl_pkg::DSrcGnt].source  = dev_d_i.source[tl_pkg::HostSourceWidth-1:0];
    arb_o[tl_pkg::DSrcGnt].denied  = dev_d_i.denied;
    arb_o[tl_pkg::DSrcGnt].corrupt = dev_d_i.corrupt;
    arb_o[tl_pkg::DSrcGnt].data    = dev_d_i.data;
    // Tagged replies answer an Acquire
    if (dev_d_i.source[tl_pkg::HostSourceWidth]) begin
      arb_o[tl_pkg::DSrcGnt].opcode = tl_pkg::GrantData;
      arb_o[tl_pkg::DSrcGnt].param  = tl_pkg::toB;
    end
  end

endmodule

// File: tl_d_arbiter.sv
`timescale 1ns/10ps

module tl_d_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [tl_pkg::DSrcNum-1:0]                   req_valid_i,
  input  tl_pkg::tl_d_host_t [tl_pkg::DSrcNum-1:0]     req_i,
  output logic [tl_pkg::DSrcNum-1:0]                   req_ready_o,
  output logic                                         out_valid_o,
  output tl_pkg::tl_d_host_t                           out_o,
  input  logic                                         out_ready_i,
  input  logic                                         last_i
);

  typedef logic [$clog2(tl_pkg::DSrcNum)-1:0] src_idx_t;

  typedef enum logic {
    ArbIdle,
    ArbLocked
  } arb_state_e;

  arb_state_e state_q, state_d;
  src_idx_t   prio_q, prio_d;
  src_idx_t   hold_q;
  src_idx_t   grant_idx;
  src_idx_t   sel_idx;
  logic       fire;

  // First valid source at or after the priority pointer
  always_comb begin
    int unsigned cand;
    grant_idx = prio_q;
    for (int k = tl_pkg::DSrcNum - 1; k >= 0; k--) begin
      cand = (prio_q + k) % tl_pkg::DSrcNum;
      if (req_valid_i[cand]) begin
        grant_idx = cand[$bits(src_idx_t)-1:0];
      end
    end
  end

  assign sel_idx     = (state_q == ArbLocked) ? hold_q : grant_idx;
  assign out_valid_o = req_valid_i[sel_idx];
  assign out_o       = req_i[sel_idx];
  assign fire        = out_valid_o && out_ready_i;

  always_comb begin
    for (int i = 0; i < tl_pkg::DSrcNum; i++) begin
      req_ready_o[i] = (sel_idx == i) && out_ready_i;
    end
  end

  //////////////////////////////////////////
  // Lock FSM
  //////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    prio_d  = prio_q;
    if (fire) begin
      if (last_i) begin
        // Burst done, the winner drops to lowest priority
        state_d = ArbIdle;
        prio_d  = (sel_idx == tl_pkg::DSrcNum - 1) ? '0 : sel_idx + 1'b1;
      end else begin
        state_d = ArbLocked;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ArbIdle;
      prio_q  <= '0;
    end else begin
      state_q <= state_d;
      prio_q  <= prio_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && state_q == ArbIdle) begin
      hold_q <= grant_idx;
    end
  end

endmodule

// File: tl_sink_allocator.sv
`timescale 1ns/10ps

module tl_sink_allocator (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  input  tl_pkg::tl_d_host_t in_i,
  output logic               in_ready_o,
  input  logic               first_i,
  output logic               host_d_valid_o,
  output tl_pkg::tl_d_host_t host_d_o,
  input  logic               host_d_ready_i,
  input  logic               host_e_valid_i,
  input  tl_pkg::tl_e_t      host_e_i
);

  logic [tl_pkg::SinkNums-1:0]  free_q, free_d;
  logic [tl_pkg::SinkWidth-1:0] sink_q;
  logic [tl_pkg::SinkWidth-1:0] avail_idx;
  logic                         avail;
  logic                         need_sink;
  logic                         stall;
  logic                         alloc;

  // Lowest free id wins
  always_comb begin
    avail     = 1'b0;
    avail_idx = '0;
    for (int i = tl_pkg::SinkNums - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        avail     = 1'b1;
        avail_idx = i[tl_pkg::SinkWidth-1:0];
      end
    end
  end

  assign need_sink = in_valid_i && first_i &&
                     (in_i.opcode inside {tl_pkg::Grant, tl_pkg::GrantData});
  assign stall     = need_sink && !avail;
  assign alloc     = need_sink && avail && host_d_ready_i;

  // A Grant with no free id is held back from the host
  assign host_d_valid_o = in_valid_i && !stall;
  assign in_ready_o     = host_d_ready_i && !stall;

  always_comb begin
    host_d_o      = in_i;
    host_d_o.sink = need_sink ? avail_idx : sink_q;
  end

  always_comb begin
    free_d = free_q;
    if (alloc) begin
      free_d[avail_idx] = 1'b0;
    end
    // GrantAck returns its id to the pool
    if (host_e_valid_i) begin
      free_d[host_e_i.sink] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

  // Later beats of a GrantData burst reuse the id of the first one
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      sink_q <= avail_idx;
    end
  end

endmodule

// File: tl_burst_tracker.sv
`timescale 1ns/10ps

module tl_burst_tracker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               d_valid_i,
  input  logic               d_ready_i,
  input  tl_pkg::tl_d_host_t d_i,
  output logic               first_o,
  output logic               last_o
);

  // Beats still to come in the message that is in flight
  logic [tl_pkg::BeatCntWidth-1:0] left_q, left_d;
  logic [tl_pkg::BeatCntWidth-1:0] beats;

  // Only data responses span more than one beat
  always_comb begin
    if (d_i.opcode inside {tl_pkg::AccessAckData, tl_pkg::GrantData}) begin
      beats = tl_pkg::burst_beats(d_i.size);
    end else begin
      beats = 1;
    end
  end

  assign first_o = (left_q == '0);
  assign last_o  = (left_q == 1) || (first_o && beats == 1);

  always_comb begin
    left_d = left_q;
    if (d_valid_i && d_ready_i) begin
      left_d = first_o ? beats - 1'b1 : left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      left_q <= '0;
    end else begin
      left_q <= left_d;
    end
  end

endmodule

// File: tl_pkg.sv
package tl_pkg;

  ////////////////////////////////////////
  // Link geometry
  ////////////////////////////////////////

  localparam int unsigned DataWidth         = 32;
  localparam int unsigned AddrWidth         = 16;
  localparam int unsigned BeatBytes         = 4;
  localparam int unsigned MaxSize           = 4;
  localparam int unsigned SizeWidth         = $clog2(MaxSize + 1);
  localparam int unsigned BeatCntWidth      = MaxSize - $clog2(BeatBytes) + 1;
  localparam int unsigned HostSourceWidth   = 2;
  // Top bit marks a Get that stands in for an Acquire
  localparam int unsigned DeviceSourceWidth = HostSourceWidth + 1;
  localparam int unsigned SinkWidth         = 2;
  localparam int unsigned SinkNums          = 4;
  localparam int unsigned RomWords          = 32;

  // Host D arbiter inputs
  localparam int unsigned DSrcNum  = 3;
  localparam int unsigned DSrcGnt  = 0;
  localparam int unsigned DSrcDeny = 1;
  localparam int unsigned DSrcRel  = 2;

  ////////////////////////////////////////
  // Opcodes and params
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4,
    AcquireBlock   = 3'd6,
    AcquirePerm    = 3'd7
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    Grant         = 3'd4,
    GrantData     = 3'd5,
    ReleaseAck    = 3'd6
  } tl_d_op_e;

  // Grow and cap codes share one 3-bit space, so toB has a code of its own
  typedef enum logic [2:0] {
    NtoB = 3'd0,
    NtoT = 3'd1,
    toN  = 3'd2,
    toB  = 3'd3
  } tl_param_e;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  typedef struct packed {
    tl_a_op_e                     opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [HostSourceWidth-1:0]   source;
    logic [AddrWidth-1:0]         address;
    logic [BeatBytes-1:0]         mask;
    logic                         corrupt;
    logic [DataWidth-1:0]         data;
  } tl_a_host_t;

  typedef struct packed {
    tl_a_op_e                     opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [DeviceSourceWidth-1:0] source;
    logic [AddrWidth-1:0]         address;
    logic [BeatBytes-1:0]         mask;
    logic                         corrupt;
    logic [DataWidth-1:0]         data;
  } tl_a_dev_t;

  typedef struct packed {
    logic [2:0]                   opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [HostSourceWidth-1:0]   source;
    logic [AddrWidth-1:0]         address;
  } tl_c_t;

  typedef struct packed {
    tl_d_op_e                     opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [HostSourceWidth-1:0]   source;
    logic [SinkWidth-1:0]         sink;
    logic                         denied;
    logic                         corrupt;
    logic [DataWidth-1:0]         data;
  } tl_d_host_t;

  typedef struct packed {
    tl_d_op_e                     opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [DeviceSourceWidth-1:0] source;
    logic                         denied;
    logic                         corrupt;
    logic [DataWidth-1:0]         data;
  } tl_d_dev_t;

  typedef struct packed {
    logic [SinkWidth-1:0]         sink;
  } tl_e_t;

  // Beats in a data burst of the given size, never fewer than one
  function automatic logic [BeatCntWidth-1:0] burst_beats(logic [SizeWidth-1:0] size);
    logic [BeatCntWidth-1:0] beats;
    beats = 1;
    if (size > $clog2(BeatBytes)) begin
      beats = beats << (size - $clog2(BeatBytes));
    end
    return beats;
  endfunction

endpackage
